// File: logic/disc_out_defines.svh
`ifndef DISC_OUT_DEFINES_SVH
`define DISC_OUT_DEFINES_SVH

// ==================================================
// Discrete output section sizing
// ==================================================

// Number of set/reset discrete outputs driven by the adapter.
`define DISC_COUNT 13

// Width of the address code G1..G7 carried with each command.
`define DISC_ADDR_BITS 7

// Length of the free-running phase cycle y1, t2, v1, t4.
`define DISC_PHASES 4

`endif

// File: logic/disc_out_pkg.sv
`default_nettype none

`include "disc_out_defines.svh"

package disc_out_pkg;

    // ==================================================
    // Shared types
    // ==================================================

    // Commands are applied at y1 and the pins are refreshed at v1.
    typedef enum logic [$clog2(`DISC_PHASES)-1:0] {
        y1 = 2'd0,
        t2 = 2'd1,
        v1 = 2'd2,
        t4 = 2'd3
    } phase_t;

    // Bit k-1 holds discrete k.
    typedef logic [`DISC_COUNT-1:0] disc_word_t;

    // Bit 0 is G1 and bit 6 is G7.
    typedef logic [`DISC_ADDR_BITS-1:0] addr_t;

endpackage

`default_nettype wire

// File: logic/disc_out_timing.sv
`default_nettype none

`include "disc_out_defines.svh"

module disc_out_timing (
    input  wire                  sim_clk,
    input  wire                  rst_n,
    input  wire                  cmd_set,
    input  wire                  cmd_reset,
    input  wire disc_out_pkg::addr_t addr,
    input  wire                  pcinf,
    input  wire                  paa,
    input  wire                  pabg1,
    input  wire                  info,
    output disc_out_pkg::phase_t phase,
    output logic                 op_set,
    output disc_out_pkg::addr_t  op_addr,
    output logic                 op_pcinf,
    output logic                 op_paa,
    output logic                 op_pabg1,
    output logic                 op_info,
    output logic                 apply_now,
    output logic                 applied
);

    logic pending;

    // ==================================================
    // Phase sequencer
    // ==================================================

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            phase <= disc_out_pkg::y1;
        end else begin
            unique case (phase)
                disc_out_pkg::y1: phase <= disc_out_pkg::t2;
                disc_out_pkg::t2: phase <= disc_out_pkg::v1;
                disc_out_pkg::v1: phase <= disc_out_pkg::t4;
                default:          phase <= disc_out_pkg::y1;
            endcase
        end
    end

    // ==================================================
    // Command capture
    // ==================================================

    // A strobe loads the direction and operand that the next y1 applies.
    always_ff @(posedge sim_clk) begin
        if (cmd_set || cmd_reset) begin
            op_set   <= cmd_set;
            op_addr  <= addr;
            op_pcinf <= pcinf;
            op_paa   <= paa;
            op_pabg1 <= pabg1;
            op_info  <= info;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (cmd_set || cmd_reset) begin
            pending <= 1'b1;
        end else if (apply_now) begin
            pending <= 1'b0;
        end
    end

    // A pending command goes to the latches at the next y1 edge.
    assign apply_now = pending && (phase == disc_out_pkg::y1);

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            applied <= 1'b0;
        end else begin
            applied <= apply_now;
        end
    end

    // The host waits for applied before it strobes again.
    a_no_overrun: assert property (@(posedge sim_clk) disable iff (!rst_n)
        (cmd_set || cmd_reset) |-> !pending);

    a_one_direction: assert property (@(posedge sim_clk) disable iff (!rst_n)
        !(cmd_set && cmd_reset));

endmodule

`default_nettype wire

// File: logic/disc_out_decode.sv
`default_nettype none

`include "disc_out_defines.svh"

module disc_out_decode (
    input  wire disc_out_pkg::addr_t  op_addr,
    input  wire                       op_pcinf,
    input  wire                       op_paa,
    input  wire                       op_pabg1,
    input  wire                       op_info,
    output disc_out_pkg::disc_word_t  select
);

    logic g1;
    logic g2;
    logic g3;
    logic g4;
    logic g5;
    logic g6;
    logic g7;

    assign g1 = op_addr[0];
    assign g2 = op_addr[1];
    assign g3 = op_addr[2];
    assign g4 = op_addr[3];
    assign g5 = op_addr[4];
    assign g6 = op_addr[5];
    assign g7 = op_addr[6];

    // ==================================================
    // Address decode table
    // ==================================================

    // Discretes 1 to 11 are program controlled and need pcinf.
    // Adjacent address bits form an edge pattern, so several rows can fire at once.
    always_comb begin
        select[0]  = op_pcinf & g4 & ~g5;
        select[1]  = op_pcinf & g5 & ~g6;
        select[2]  = op_pcinf & g6 & ~g7;
        select[3]  = op_pcinf & g7 & g1;
        select[4]  = op_pcinf & g2 & ~g1;
        select[5]  = op_pcinf & g3 & ~g2;
        select[6]  = op_pcinf & g4 & ~g3;
        select[7]  = op_pcinf & g5 & ~g4;
        select[8]  = op_pcinf & g6 & ~g5;
        select[9]  = op_pcinf & g7 & ~g6;
        select[10] = op_pcinf & ~g7 & ~g1;

        // Discrete 12 ignores the address code entirely.
        select[11] = op_pabg1 & op_info;

        // Discrete 13 is qualified by PAA.
        select[`DISC_COUNT-1] = op_paa & op_info & g2 & ~g3;
    end

endmodule

`default_nettype wire

// File: logic/disc_out_regs.sv
`default_nettype none

`include "disc_out_defines.svh"

module disc_out_regs (
    input  wire                            sim_clk,
    input  wire                            rst_n,
    input  wire                            apply_now,
    input  wire                            op_set,
    input  wire disc_out_pkg::disc_word_t  select,
    output disc_out_pkg::disc_word_t       latch
);

    disc_out_pkg::disc_word_t latch_next;

    // ==================================================
    // Set/reset discrete latches
    // ==================================================

    // A set command turns on every selected bit and a reset command clears them.
    always_comb begin
        if (op_set) begin
            latch_next = latch | select;
        end else begin
            latch_next = latch & ~select;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            latch <= '0;
        end else if (apply_now) begin
            latch <= latch_next;
        end
    end

    // Only bits chosen by the decode of the applied command may move.
    a_unselected_hold: assert property (@(posedge sim_clk) disable iff (!rst_n)
        ((latch ^ $past(latch)) & ~($past(select) & {`DISC_COUNT{$past(apply_now)}})) == '0);

endmodule

`default_nettype wire

// File: logic/disc_out_drivers.sv
`default_nettype none

`include "disc_out_defines.svh"

module disc_out_drivers (
    input  wire                            sim_clk,
    input  wire                            rst_n,
    input  wire disc_out_pkg::phase_t      phase,
    input  wire                            inhibit,
    input  wire disc_out_pkg::disc_word_t  latch,
    output disc_out_pkg::disc_word_t       disc
);

    // ==================================================
    // Output pin stage
    // ==================================================

    // Inhibit forces the pins off but leaves the latches alone.
    // the pins pick up the latches again at the next v1
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            disc <= '0;
        end else if (inhibit) begin
            disc <= '0;
        end else if (phase == disc_out_pkg::v1) begin
            disc <= latch;
        end
    end

    a_inhibit_off: assert property (@(posedge sim_clk) disable iff (!rst_n)
        inhibit |=> (disc == {`DISC_COUNT{1'b0}}));

endmodule

`default_nettype wire

// File: logic/disc_out_unit.sv
`default_nettype none

`include "disc_out_defines.svh"

module disc_out_unit (
    input  wire                            sim_clk,
    input  wire                            rst_n,
    input  wire                            cmd_set,
    input  wire                            cmd_reset,
    input  wire disc_out_pkg::addr_t       addr,
    input  wire                            pcinf,
    input  wire                            paa,
    input  wire                            pabg1,
    input  wire                            info,
    input  wire                            inhibit,
    output wire                            applied,
    output disc_out_pkg::disc_word_t       disc
);

    disc_out_pkg::phase_t     phase;
    disc_out_pkg::addr_t      op_addr;
    disc_out_pkg::disc_word_t select;
    disc_out_pkg::disc_word_t latch;
    wire                      op_set;
    wire                      op_pcinf;
    wire                      op_paa;
    wire                      op_pabg1;
    wire                      op_info;
    wire                      apply_now;

    // ==================================================
    // Command path
    // ==================================================

    disc_out_timing u_timing (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .cmd_set   (cmd_set),
        .cmd_reset (cmd_reset),
        .addr      (addr),
        .pcinf     (pcinf),
        .paa       (paa),
        .pabg1     (pabg1),
        .info      (info),
        .phase     (phase),
        .op_set    (op_set),
        .op_addr   (op_addr),
        .op_pcinf  (op_pcinf),
        .op_paa    (op_paa),
        .op_pabg1  (op_pabg1),
        .op_info   (op_info),
        .apply_now (apply_now),
        .applied   (applied)
    );

    disc_out_decode u_decode (
        .op_addr  (op_addr),
        .op_pcinf (op_pcinf),
        .op_paa   (op_paa),
        .op_pabg1 (op_pabg1),
        .op_info  (op_info),
        .select   (select)
    );

    // ==================================================
    // Storage and pins
    // ==================================================

    disc_out_regs u_regs (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .apply_now (apply_now),
        .op_set    (op_set),
        .select    (select),
        .latch     (latch)
    );

    disc_out_drivers u_drivers (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .phase   (phase),
        .inhibit (inhibit),
        .latch   (latch),
        .disc    (disc)
    );

endmodule

`default_nettype wire

// File: tests/disc_out_tb.sv
`default_nettype none

module disc_out_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM = 300;
    localparam int NUM_INHIBITED = 20;
    localparam int NUM_CMDS = 26 + NUM_RANDOM + NUM_INHIBITED;
    localparam int WATCHDOG_CYCLES = NUM_CMDS * 12 + RESET_CYCLES + 64;

    logic sim_clk;
    logic rst_n;
    logic cmd_set;
    logic cmd_reset;
    disc_out_pkg::addr_t addr;
    logic pcinf;
    logic paa;
    logic pabg1;
    logic info;
    logic inhibit;
    wire applied;
    disc_out_pkg::disc_word_t disc;

    disc_out_pkg::disc_word_t model_word;
    disc_out_pkg::disc_word_t expected;
    int sent_count;
    int applied_count;
    int checks_requested;
    int checks_done;

    disc_out_unit uut (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .cmd_set   (cmd_set),
        .cmd_reset (cmd_reset),
        .addr      (addr),
        .pcinf     (pcinf),
        .paa       (paa),
        .pabg1     (pabg1),
        .info      (info),
        .inhibit   (inhibit),
        .applied   (applied),
        .disc      (disc)
    );

    initial begin
        sim_clk = 1'b0;
        forever #10 sim_clk = ~sim_clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    // ==================================================
    // Reference model
    // ==================================================

    function automatic disc_out_pkg::disc_word_t next_word(
            input disc_out_pkg::disc_word_t word, input logic set_dir,
            input disc_out_pkg::addr_t a, input logic q_pcinf, input logic q_paa,
            input logic q_pabg1, input logic q_info);
        disc_out_pkg::disc_word_t sel;
        logic [7:1] g;
        g = a;
        sel = '0;
        if (q_pcinf) begin
            // Rows 1 to 3 and 5 to 10 look for a high G bit next to a low one.
            for (int r = 1; r <= 3; r++) begin
                sel[r-1] = g[r+3] && !g[r+4];
            end
            for (int r = 5; r <= 10; r++) begin
                sel[r-1] = g[r-3] && !g[r-4];
            end
            sel[3] = g[7] && g[1];
            sel[10] = !g[7] && !g[1];
        end
        sel[11] = q_pabg1 && q_info;
        sel[12] = q_paa && q_info && g[2] && !g[3];
        return set_dir ? (word | sel) : (word & ~sel);
    endfunction

    // One address per table row that makes that row true.
    function automatic disc_out_pkg::addr_t row_address(input int row);
        case (row)
            1:       return 7'b0001000;
            2:       return 7'b0010000;
            3:       return 7'b0100000;
            4:       return 7'b1000001;
            5:       return 7'b0000010;
            6:       return 7'b0000100;
            7:       return 7'b0011000;
            8:       return 7'b0110000;
            9:       return 7'b1100000;
            10:      return 7'b1000000;
            13:      return 7'b0000010;
            default: return '0;
        endcase
    endfunction

    // ==================================================
    // Stimulus and checks
    // ==================================================

    task automatic request_check();
        @(posedge sim_clk);
        checks_requested++;
        wait (checks_done == checks_requested);
    endtask

    task automatic send_command(input logic set_dir, input disc_out_pkg::addr_t a,
                                input logic q_pcinf, input logic q_paa,
                                input logic q_pabg1, input logic q_info);
        int latency;
        @(posedge sim_clk);
        cmd_set   <= set_dir;
        cmd_reset <= !set_dir;
        addr      <= a;
        pcinf     <= q_pcinf;
        paa       <= q_paa;
        pabg1     <= q_pabg1;
        info      <= q_info;
        model_word = next_word(model_word, set_dir, a, q_pcinf, q_paa, q_pabg1, q_info);
        sent_count++;
        @(posedge sim_clk);
        cmd_set   <= 1'b0;
        cmd_reset <= 1'b0;
        // The strobe was captured at this edge, so latency counts from here.
        latency = 0;
        @(negedge sim_clk);
        assert (!applied) else report_failure("applied rose before the strobe was captured");
        while (!applied && latency < 4) begin
            @(negedge sim_clk);
            latency++;
        end
        assert (applied) else report_failure("applied did not arrive within 4 cycles of a strobe");
        repeat (5) begin
            @(negedge sim_clk);
            assert (!applied) else report_failure("applied pulsed more than once for one strobe");
        end
        request_check();
    endtask

    task automatic send_random_command();
        logic [31:0] rnd;
        rnd = $urandom;
        send_command(rnd[12], rnd[6:0], rnd[8], rnd[9], rnd[10], rnd[11]);
    endtask

    always @(negedge sim_clk) begin
        if (applied) begin
            applied_count++;
        end
        if (checks_done != checks_requested) begin
            expected = inhibit ? '0 : model_word;
            assert (disc == expected)
                else report_failure($sformatf("Error: disc expected %h actual %h", expected, disc));
            checks_done++;
        end
    end

    initial begin
        void'($urandom(32'h27880787));
        rst_n = 1'b0;
        cmd_set = 1'b0;
        cmd_reset = 1'b0;
        addr = '0;
        pcinf = 1'b0;
        paa = 1'b0;
        pabg1 = 1'b0;
        info = 1'b0;
        inhibit = 1'b0;
        model_word = '0;
        repeat (RESET_CYCLES) @(posedge sim_clk);
        rst_n <= 1'b1;
        repeat (8) begin
            @(negedge sim_clk);
            assert (disc == '0)
                else report_failure($sformatf("Error: disc expected %h actual %h", 13'h0, disc));
            assert (!applied) else report_failure("applied pulsed before any strobe");
        end
        for (int row = 1; row <= 13; row++) begin
            send_command(1'b1, row_address(row), row <= 11, row == 13, row == 12, row >= 12);
            send_command(1'b0, row_address(row), row <= 11, row == 13, row == 12, row >= 12);
        end
        repeat (NUM_RANDOM) send_random_command();
        // Pins stay off under inhibit while the latches keep following commands.
        @(posedge sim_clk);
        inhibit <= 1'b1;
        repeat (NUM_INHIBITED) send_random_command();
        @(posedge sim_clk);
        inhibit <= 1'b0;
        repeat (3) @(posedge sim_clk);
        request_check();
        if (applied_count == sent_count) begin
            $display("test passed");
            $finish;
        end else begin
            report_failure($sformatf("Error: applied count expected %h actual %h",
                                     sent_count, applied_count));
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sim_clk);
        report_failure("Timeout: applied never arrived and the run did not complete");
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/disc_out_pkg.sv
logic/disc_out_timing.sv
logic/disc_out_decode.sv
logic/disc_out_regs.sv
logic/disc_out_drivers.sv
logic/disc_out_unit.sv
tests/disc_out_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module disc_out_tb -f sim.f -o disc_out_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/disc_out_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "test passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
